/* Makefile */
SRCS = $(wildcard common/*.sv common/*.svh design/*.sv edit_mem_read_data/*.sv verification/*.sv)

all: obj_dir/Vedit_read_tb

obj_dir/Vedit_read_tb: list.f $(SRCS)
	verilator --binary --timing --assert --top-module edit_read_tb -f list.f

run: obj_dir/Vedit_read_tb
	./obj_dir/Vedit_read_tb

clean:
	rm -rf obj_dir

.PHONY: all run clean

/* common/edit_rd_cfg.svh */
/*
 * Packet edit memory read side.
 * Widths and queue depths shared by the subsystem.
 */
`ifndef EDIT_RD_CFG_SVH
`define EDIT_RD_CFG_SVH

`define EDIT_BPTR_NBITS 6 // buffer pointer
`define EDIT_PORT_NBITS 2
`define EDIT_NUM_PORTS 4
`define EDIT_LSB_NBITS 2 // chunk bits below the pointer
`define EDIT_ADDR_NBITS (`EDIT_BPTR_NBITS + `EDIT_LSB_NBITS)
`define EDIT_DATA_NBITS 32

// queue depths
`define EDIT_CMD_FIFO_DEPTH 16
`define EDIT_PORT_FIFO_DEPTH 2 // one link answer in flight per port
`define EDIT_ID_FIFO_DEPTH 8

`endif

/* common/edit_rd_pkg.sv */
/*
 * Packet edit read types.
 * Command, queued head, data request, output word and table writes.
 */
`default_nettype none
`include "edit_rd_cfg.svh"

package edit_rd_pkg;

	typedef struct packed {
		logic [`EDIT_ADDR_NBITS-1:0] raddr;
		logic [`EDIT_PORT_NBITS-1:0] port_id;
		logic                        eop;
	} edit_cmd_t;

	// command as held in the order queue
	typedef struct packed {
		logic [`EDIT_BPTR_NBITS-1:0] buf_ptr;
		logic                        sop;
		logic [`EDIT_PORT_NBITS-1:0] port_id;
		logic                        eop;
	} edit_head_t;

	typedef struct packed {
		logic [`EDIT_PORT_NBITS-1:0] port_id;
		logic                        sop;
		logic                        eop;
		logic [`EDIT_BPTR_NBITS-1:0] buf_ptr;
	} data_req_t;

	typedef struct packed {
		logic [`EDIT_PORT_NBITS-1:0] port_id;
		logic                        sop;
		logic                        eop;
		logic [`EDIT_DATA_NBITS-1:0] data;
	} edit_out_t;

	typedef struct packed {
		logic [`EDIT_BPTR_NBITS-1:0] addr;
		logic [`EDIT_BPTR_NBITS-1:0] next_ptr;
	} link_wr_t;

	typedef struct packed {
		logic [`EDIT_BPTR_NBITS-1:0] addr;
		logic [`EDIT_DATA_NBITS-1:0] data;
	} data_wr_t;

endpackage

`default_nettype wire

/* design/buf_data_mem.sv */
/*
 * Buffer data memory.
 * One data word per buffer; two-stage read carries the request tags out.
 */
`default_nettype none
`include "edit_rd_cfg.svh"

module buf_data_mem (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   data_wr_en,
	input  edit_rd_pkg::data_wr_t  data_wr,
	input  logic                   data_req,
	input  edit_rd_pkg::data_req_t data_req_info,
	output logic                   out_valid,
	output edit_rd_pkg::edit_out_t out
);

	localparam int NUM_BUFS = 1 << `EDIT_BPTR_NBITS;

	logic [`EDIT_DATA_NBITS-1:0] data_tbl [NUM_BUFS];
	logic s1_valid;
	logic [`EDIT_DATA_NBITS-1:0] s1_word;
	edit_rd_pkg::data_req_t s1_tag;

	always_ff @(posedge clk) begin
		if (data_wr_en)
			data_tbl[data_wr.addr] <= data_wr.data;
	end

	always_ff @(posedge clk) begin
		s1_word <= data_tbl[data_req_info.buf_ptr];
		s1_tag <= data_req_info; // port and flags ride along
		out.port_id <= s1_tag.port_id;
		out.sop <= s1_tag.sop;
		out.eop <= s1_tag.eop;
		out.data <= s1_word;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_valid <= data_req;
			out_valid <= s1_valid;
		end
	end

endmodule

`default_nettype wire

/* design/buf_link_mem.sv */
/*
 * Buffer link memory.
 * Next-buffer pointer per buffer, loaded through a write port,
 * looked up with a fixed two-cycle answer.
 */
`default_nettype none
`include "edit_rd_cfg.svh"

module buf_link_mem (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        link_wr_en,
	input  edit_rd_pkg::link_wr_t       link_wr,
	input  logic                        buf_req,
	input  logic [`EDIT_BPTR_NBITS-1:0] buf_req_ptr,
	output logic                        buf_ack_valid,
	output logic [`EDIT_BPTR_NBITS-1:0] buf_ack_ptr
);

	localparam int NUM_BUFS = 1 << `EDIT_BPTR_NBITS;

	logic [`EDIT_BPTR_NBITS-1:0] link_tbl [NUM_BUFS];
	logic s1_valid;
	logic [`EDIT_BPTR_NBITS-1:0] s1_ptr;

	always_ff @(posedge clk) begin
		if (link_wr_en)
			link_tbl[link_wr.addr] <= link_wr.next_ptr;
	end

	// stage one reads the table
	always_ff @(posedge clk) begin
		s1_ptr <= link_tbl[buf_req_ptr];
	end

	// stage two drives the answer
	always_ff @(posedge clk) begin
		buf_ack_ptr <= s1_ptr;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			buf_ack_valid <= 1'b0;
		end else begin
			s1_valid <= buf_req;
			buf_ack_valid <= s1_valid;
		end
	end

endmodule

`default_nettype wire

/* design/edit_read_top.sv */
/*
 * Edit memory read subsystem top.
 * Control block with its link and data memories.
 */
`default_nettype none
`include "edit_rd_cfg.svh"

module edit_read_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cmd_valid,
	input  edit_rd_pkg::edit_cmd_t cmd,
	output logic                   cmd_ready,
	input  logic                   link_wr_en,
	input  edit_rd_pkg::link_wr_t  link_wr,
	input  logic                   data_wr_en,
	input  edit_rd_pkg::data_wr_t  data_wr,
	output logic                   out_valid,
	output edit_rd_pkg::edit_out_t out
);

	logic buf_req;
	logic [`EDIT_BPTR_NBITS-1:0] buf_req_ptr;
	logic buf_ack_valid;
	logic [`EDIT_BPTR_NBITS-1:0] buf_ack_ptr;
	logic data_req;
	edit_rd_pkg::data_req_t data_req_info;

	edit_mem_read_data edit_mem_read_data_i (
		.clk(clk), .reset(reset),
		.cmd_valid(cmd_valid), .cmd(cmd), .cmd_ready(cmd_ready),
		.buf_ack_valid(buf_ack_valid), .buf_ack_ptr(buf_ack_ptr),
		.buf_req(buf_req), .buf_req_ptr(buf_req_ptr),
		.data_req(data_req), .data_req_info(data_req_info)
	);

	buf_link_mem buf_link_mem_i (
		.clk(clk), .reset(reset),
		.link_wr_en(link_wr_en), .link_wr(link_wr),
		.buf_req(buf_req), .buf_req_ptr(buf_req_ptr),
		.buf_ack_valid(buf_ack_valid), .buf_ack_ptr(buf_ack_ptr)
	);

	buf_data_mem buf_data_mem_i (
		.clk(clk), .reset(reset),
		.data_wr_en(data_wr_en), .data_wr(data_wr),
		.data_req(data_req), .data_req_info(data_req_info),
		.out_valid(out_valid), .out(out)
	);

endmodule

`default_nettype wire

/* design/sync_fifo.sv */
/*
 * Synchronous show-ahead FIFO.
 * Payload type and depth are parameters; dout shows the head entry.
 */
`default_nettype none

module sync_fifo #(
	parameter type T = logic,
	parameter int DEPTH = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic wr,
	input  T     din,
	input  logic rd,
	output T     dout,
	output logic empty,
	output logic full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

	T mem [DEPTH];
	logic [AW-1:0] wptr;
	logic [AW-1:0] rptr;
	logic [CW-1:0] count;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr & ~full; // writes to a full queue are dropped
	assign do_rd = rd & ~empty;
	assign empty = (count == '0);
	assign full = (count == CW'(DEPTH));
	assign dout = mem[rptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wptr <= (wptr == LAST) ? '0 : wptr + 1'b1;
			if (do_rd)
				rptr <= (rptr == LAST) ? '0 : rptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

/* edit_mem_read_data/edit_mem_read_data.sv */
/*
 * Edit memory read control.
 * Keeps command order, follows each port's buffer chain through the
 * link memory and issues data reads with their tags.
 */
`default_nettype none
`include "edit_rd_cfg.svh"

module edit_mem_read_data (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             cmd_valid,
	input  edit_rd_pkg::edit_cmd_t           cmd,
	output logic                             cmd_ready,
	input  logic                             buf_ack_valid,
	input  logic [`EDIT_BPTR_NBITS-1:0]      buf_ack_ptr,
	output logic                             buf_req,
	output logic [`EDIT_BPTR_NBITS-1:0]      buf_req_ptr,
	output logic                             data_req,
	output edit_rd_pkg::data_req_t           data_req_info
);

	logic active; // low in reset and for the first cycle out of it

	// command order queue
	edit_rd_pkg::edit_head_t cmd_head_in;
	edit_rd_pkg::edit_head_t head;
	logic cmd_fifo_wr;
	logic cmd_fifo_full;
	logic cmd_fifo_empty;
	logic head_rd;
	logic [`EDIT_BPTR_NBITS-1:0] head_ptr; // resolved buffer pointer

	// per-port next pointer queues
	logic [`EDIT_NUM_PORTS-1:0] pf_wr;
	logic [`EDIT_NUM_PORTS-1:0] pf_rd;
	logic [`EDIT_NUM_PORTS-1:0] pf_empty;
	logic [`EDIT_BPTR_NBITS-1:0] pf_dout [`EDIT_NUM_PORTS];

	// link answer routing
	logic ack_valid_d1;
	logic [`EDIT_BPTR_NBITS-1:0] ack_ptr_d1;
	logic id_fifo_wr;
	logic id_fifo_empty;
	logic [`EDIT_PORT_NBITS-1:0] id_fifo_dout;

	always_ff @(posedge clk) begin
		if (reset)
			active <= 1'b0;
		else
			active <= 1'b1;
	end

	assign cmd_ready = active & ~cmd_fifo_full;
	assign cmd_fifo_wr = cmd_valid & cmd_ready;

	// split address into buffer pointer and chunk bits
	assign cmd_head_in.buf_ptr = cmd.raddr[`EDIT_ADDR_NBITS-1:`EDIT_LSB_NBITS];
	assign cmd_head_in.sop = ~|cmd.raddr[`EDIT_LSB_NBITS-1:0];
	assign cmd_head_in.port_id = cmd.port_id;
	assign cmd_head_in.eop = cmd.eop;

	sync_fifo #(.T(edit_rd_pkg::edit_head_t), .DEPTH(`EDIT_CMD_FIFO_DEPTH)) cmd_fifo_i (
		.clk(clk), .reset(reset),
		.wr(cmd_fifo_wr), .din(cmd_head_in),
		.rd(head_rd), .dout(head),
		.empty(cmd_fifo_empty), .full(cmd_fifo_full)
	);

	// sop needs no lookup, later chunks wait for their port's next pointer
	assign head_rd = ~cmd_fifo_empty & (head.sop | ~pf_empty[head.port_id]);
	assign head_ptr = head.sop ? head.buf_ptr : pf_dout[head.port_id];
	assign id_fifo_wr = head_rd & ~head.eop;

	always_comb begin
		for (int i = 0; i < `EDIT_NUM_PORTS; i++) begin
			pf_wr[i] = ack_valid_d1 & (id_fifo_dout == `EDIT_PORT_NBITS'(i));
			pf_rd[i] = head_rd & ~head.sop & (head.port_id == `EDIT_PORT_NBITS'(i));
		end
	end

	for (genvar gi = 0; gi < `EDIT_NUM_PORTS; gi++) begin : g_port
		sync_fifo #(.T(logic [`EDIT_BPTR_NBITS-1:0]), .DEPTH(`EDIT_PORT_FIFO_DEPTH)) ptr_fifo_i (
			.clk(clk), .reset(reset),
			.wr(pf_wr[gi]), .din(ack_ptr_d1),
			.rd(pf_rd[gi]), .dout(pf_dout[gi]),
			.empty(pf_empty[gi]), .full()
		);
	end

	// ports waiting on a link answer, oldest first
	sync_fifo #(.T(logic [`EDIT_PORT_NBITS-1:0]), .DEPTH(`EDIT_ID_FIFO_DEPTH)) id_fifo_i (
		.clk(clk), .reset(reset),
		.wr(id_fifo_wr), .din(head.port_id),
		.rd(ack_valid_d1), .dout(id_fifo_dout),
		.empty(id_fifo_empty), .full()
	);

	always_ff @(posedge clk) begin
		if (reset)
			ack_valid_d1 <= 1'b0;
		else
			ack_valid_d1 <= buf_ack_valid;
	end

	always_ff @(posedge clk) begin
		ack_ptr_d1 <= buf_ack_ptr;
		buf_req_ptr <= head_ptr; // same pointer goes to both memories
		data_req_info.port_id <= head.port_id;
		data_req_info.sop <= head.sop;
		data_req_info.eop <= head.eop;
		data_req_info.buf_ptr <= head_ptr;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			data_req <= 1'b0;
			buf_req <= 1'b0;
		end else begin
			data_req <= head_rd;
			buf_req <= id_fifo_wr; // last chunk needs no next buffer
		end
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+common
common/edit_rd_pkg.sv
design/sync_fifo.sv
edit_mem_read_data/edit_mem_read_data.sv
design/buf_link_mem.sv
design/buf_data_mem.sv
design/edit_read_top.sv
verification/edit_read_sva.sv
verification/edit_read_tb.sv

/* verification/edit_read_stim.txt */
# L <buf ptr> <next ptr> | D <buf ptr> <data word> | C <raddr> <port> <eop>
# all fields in hex
L 0a 17
L 17 07
L 21 0c
L 0f 3c
L 3c 03
L 03 2c
D 05 a1b2c3d4
D 0a 10000001
D 17 10000002
D 07 10000003
D 21 20000001
D 0c 20000002
D 0f 30000001
D 3c 30000002
D 03 30000003
D 2c 30000004
C 14 0 1
C 28 1 0
C 84 2 0
C 29 1 0
C 85 2 1
C 2a 1 1
C 3c 3 0
C 3d 3 0
C 3e 3 0
C 3f 3 1

/* verification/edit_read_sva.sv */
/*
 * Edit read control assertions.
 * Command queue, link answer routing and reset behavior.
 */
`default_nettype none

module edit_read_sva (
	input logic clk,
	input logic reset,
	input logic cmd_fifo_wr,
	input logic cmd_fifo_empty,
	input logic ack_valid_d1,
	input logic id_fifo_empty,
	input logic data_req
);

	// an accepted command is in the queue the next cycle
	a_wr_lands: assert property (@(posedge clk) disable iff (reset)
		cmd_fifo_wr |=> !cmd_fifo_empty)
		else $error("accepted command missing from the command queue");

	// every registered answer needs a port waiting for it
	a_ack_has_port: assert property (@(posedge clk) disable iff (reset)
		ack_valid_d1 |-> !id_fifo_empty)
		else $error("link answer with no waiting port id");

	a_quiet_after_reset: assert property (@(posedge clk)
		$fell(reset) |=> !data_req)
		else $error("data_req high right after reset");

endmodule

`default_nettype wire

/* verification/edit_read_tb.sv */
/*
 * Edit memory read testbench.
 * Loads tables and commands from the stim file, models each port's
 * buffer chain and checks every output word in command order.
 */
`default_nettype none
`include "edit_rd_cfg.svh"

module edit_read_tb;

	localparam int NUM_BUFS = 1 << `EDIT_BPTR_NBITS;
	localparam int REPS = 4; // last pass gets random gaps

	logic clk;
	logic reset;
	logic cmd_valid;
	edit_rd_pkg::edit_cmd_t cmd;
	logic cmd_ready;
	logic link_wr_en;
	edit_rd_pkg::link_wr_t link_wr;
	logic data_wr_en;
	edit_rd_pkg::data_wr_t data_wr;
	logic out_valid;
	edit_rd_pkg::edit_out_t out;

	edit_rd_pkg::link_wr_t link_q[$];
	edit_rd_pkg::data_wr_t data_q[$];
	edit_rd_pkg::edit_cmd_t cmd_q[$];
	edit_rd_pkg::edit_out_t exp_q[$];
	logic [`EDIT_BPTR_NBITS-1:0] link_ref [NUM_BUFS];
	logic [`EDIT_DATA_NBITS-1:0] data_ref [NUM_BUFS];
	int got_count = 0;
	int total = 0;
	int limit = 0;
	int cycles = 0;

	edit_read_top edit_read_top_i (
		.clk(clk), .reset(reset),
		.cmd_valid(cmd_valid), .cmd(cmd), .cmd_ready(cmd_ready),
		.link_wr_en(link_wr_en), .link_wr(link_wr),
		.data_wr_en(data_wr_en), .data_wr(data_wr),
		.out_valid(out_valid), .out(out)
	);

	bind edit_mem_read_data edit_read_sva edit_read_sva_i (
		.clk(clk), .reset(reset),
		.cmd_fifo_wr(cmd_fifo_wr), .cmd_fifo_empty(cmd_fifo_empty),
		.ack_valid_d1(ack_valid_d1), .id_fifo_empty(id_fifo_empty),
		.data_req(data_req)
	);

	always #4 clk = ~clk;

	task automatic load_stim();
		int fd;
		int n;
		string line;
		byte kind;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		edit_rd_pkg::edit_cmd_t c;
		fd = $fopen("verification/edit_read_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			$display("=== FAIL ===");
			$fatal(1, "no stimulus");
		end
		while ($fgets(line, fd) > 0) begin
			kind = 8'h00; // blank and comment lines match nothing
			n = $sscanf(line, "%c %h %h %h", kind, f1, f2, f3);
			if (kind == "L" && n >= 3) begin
				link_q.push_back({f1[`EDIT_BPTR_NBITS-1:0], f2[`EDIT_BPTR_NBITS-1:0]});
				link_ref[f1[`EDIT_BPTR_NBITS-1:0]] = f2[`EDIT_BPTR_NBITS-1:0];
			end else if (kind == "D" && n >= 3) begin
				data_q.push_back({f1[`EDIT_BPTR_NBITS-1:0], f2[`EDIT_DATA_NBITS-1:0]});
				data_ref[f1[`EDIT_BPTR_NBITS-1:0]] = f2[`EDIT_DATA_NBITS-1:0];
			end else if (kind == "C" && n >= 4) begin
				c.raddr = f1[`EDIT_ADDR_NBITS-1:0];
				c.port_id = f2[`EDIT_PORT_NBITS-1:0];
				c.eop = f3[0];
				cmd_q.push_back(c);
			end
		end
		$fclose(fd);
	endtask

	// expected words from the chain rules, one pass per repetition
	function automatic void build_expected();
		logic [`EDIT_BPTR_NBITS-1:0] prev [`EDIT_NUM_PORTS];
		logic [`EDIT_BPTR_NBITS-1:0] ptr;
		logic sop;
		edit_rd_pkg::edit_out_t e;
		for (int r = 0; r < REPS; r++) begin
			foreach (cmd_q[i]) begin
				sop = (cmd_q[i].raddr[`EDIT_LSB_NBITS-1:0] == '0);
				if (sop)
					ptr = cmd_q[i].raddr[`EDIT_ADDR_NBITS-1:`EDIT_LSB_NBITS];
				else
					ptr = link_ref[prev[cmd_q[i].port_id]]; // next buffer in the chain
				prev[cmd_q[i].port_id] = ptr;
				e.port_id = cmd_q[i].port_id;
				e.sop = sop;
				e.eop = cmd_q[i].eop;
				e.data = data_ref[ptr];
				exp_q.push_back(e);
			end
		end
	endfunction

	task automatic write_tables();
		foreach (link_q[i]) begin
			@(negedge clk);
			link_wr_en = 1'b1;
			link_wr = link_q[i];
		end
		@(negedge clk);
		link_wr_en = 1'b0;
		foreach (data_q[i]) begin
			@(negedge clk);
			data_wr_en = 1'b1;
			data_wr = data_q[i];
		end
		@(negedge clk);
		data_wr_en = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			cmd_valid = 1'b0;
		end
	endtask

	// held until cmd_ready, transfer on the next rising edge
	task automatic send_cmd(input edit_rd_pkg::edit_cmd_t c);
		@(negedge clk);
		cmd_valid = 1'b1;
		cmd = c;
		while (!cmd_ready)
			@(negedge clk);
	endtask

	task automatic check_out(input edit_rd_pkg::edit_out_t exp, input edit_rd_pkg::edit_out_t got);
		bit bad;
		bad = 1'b0;
		if (got.port_id !== exp.port_id) begin
			$display("[FAIL] out.port_id expected 0x%h got 0x%h", exp.port_id, got.port_id);
			bad = 1'b1;
		end
		if (got.sop !== exp.sop) begin
			$display("[FAIL] out.sop expected 0x%h got 0x%h", exp.sop, got.sop);
			bad = 1'b1;
		end
		if (got.eop !== exp.eop) begin
			$display("[FAIL] out.eop expected 0x%h got 0x%h", exp.eop, got.eop);
			bad = 1'b1;
		end
		if (got.data !== exp.data) begin
			$display("[FAIL] out.data expected 0x%h got 0x%h", exp.data, got.data);
			bad = 1'b1;
		end
		if (bad) begin
			$display("=== FAIL ===");
			$fatal(1, "wrong output word %0d", got_count);
		end
	endtask

	always @(negedge clk) begin
		if (!reset && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("an output word arrived with no command left to answer");
				$display("=== FAIL ===");
				$fatal(1, "extra output");
			end else begin
				check_out(exp_q.pop_front(), out);
				got_count++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout after %0d cycles, %0d of %0d words seen", cycles, got_count, total);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	initial begin
		void'($urandom(97143));
		clk = 1'b0;
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		link_wr_en = 1'b0;
		link_wr = '0;
		data_wr_en = 1'b0;
		data_wr = '0;
		load_stim();
		build_expected();
		total = exp_q.size();
		limit = 64 * total + 200;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		write_tables();
		for (int r = 0; r < REPS; r++) begin
			foreach (cmd_q[i]) begin
				if (r == REPS - 1)
					idle_cycles(int'($urandom % 5));
				send_cmd(cmd_q[i]);
			end
		end
		@(negedge clk);
		cmd_valid = 1'b0;
		while (got_count < total)
			@(negedge clk);
		repeat (16) @(negedge clk); // room for stray words
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire
